/* sdram_params.svh */
////////////////////////////////////////////////////////////
// SDRAM controller parameters
// Geometry, CAS latency, cycle timings and pin command codes
////////////////////////////////////////////////////////////

`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// Geometry and read latency
`define SDRAM_DATA_WIDTH 32
`define SDRAM_DQM_WIDTH 4
`define SDRAM_ROW_WIDTH 11
`define SDRAM_COL_WIDTH 8
`define SDRAM_BANK_WIDTH 2
`define SDRAM_ADDR_WIDTH 21
`define SDRAM_CAS_LATENCY 2
`define SDRAM_FAST_INPUT 1

// Init milestones, in cycles after reset falls
`define SDRAM_INIT_CKE_CYCLES 20
`define SDRAM_INIT_PRECHARGE_CYCLES 40
`define SDRAM_T_RP_CYCLES 3
`define SDRAM_T_RFC_CYCLES 10
`define SDRAM_T_MRD_CYCLES 2

// Access and refresh timing
`define SDRAM_T_RCD_CYCLES 3
// tWR plus tRP after a write with auto precharge
`define SDRAM_WRITE_RECOVERY_CYCLES 6
`define SDRAM_REFRESH_INTERVAL 200

// Commands as nCS, nRAS, nCAS, nWE
`define SDRAM_CMD_NOP 4'b0111
`define SDRAM_CMD_ACTIVE 4'b0011
`define SDRAM_CMD_READ 4'b0101
`define SDRAM_CMD_WRITE 4'b0100
`define SDRAM_CMD_PRECHARGE 4'b0010
`define SDRAM_CMD_REFRESH 4'b0001
`define SDRAM_CMD_LOAD_MODE 4'b0000

`endif

/* sdram_bus_pkg.sv */
////////////////////////////////////////////////////////////
// SDRAM A-bus word
// One address word read as row, column command or mode
////////////////////////////////////////////////////////////

`default_nettype none

`include "sdram_params.svh"

package sdram_bus_pkg;

  // Same 11 pins, decoded by the command that goes with them
  typedef union packed {
    logic [`SDRAM_ROW_WIDTH-1:0] row;
    struct packed {
      // A10 high closes the row after the access
      logic auto_precharge;
      logic [`SDRAM_ROW_WIDTH-`SDRAM_COL_WIDTH-2:0] unused;
      logic [`SDRAM_COL_WIDTH-1:0] col;
    } col_cmd;
    struct packed {
      logic reserved;
      logic write_burst_single;
      logic [1:0] op_mode;
      logic [2:0] cas_latency;
      logic burst_type;
      logic [2:0] burst_length;
    } mode;
  } sdram_a_word_t;

  // Mode register for single word access, sequential, fixed CL
  function automatic sdram_a_word_t sdram_mode_word();
    sdram_a_word_t w;
    w.mode.reserved = 1'b0;
    w.mode.write_burst_single = 1'b1;
    w.mode.op_mode = 2'b00;
    w.mode.cas_latency = 3'(`SDRAM_CAS_LATENCY);
    w.mode.burst_type = 1'b0;
    // Code 0 selects a burst of one word
    w.mode.burst_length = 3'b000;
    return w;
  endfunction

endpackage

`default_nettype wire

/* sdram_port_pkg.sv */
////////////////////////////////////////////////////////////
// Port address helpers
// Split a port word address into bank, row and column
////////////////////////////////////////////////////////////

`default_nettype none

`include "sdram_params.svh"

package sdram_port_pkg;

  // Bank sits in the top bits
  function automatic logic [`SDRAM_BANK_WIDTH-1:0] port_bank(
    input logic [`SDRAM_ADDR_WIDTH-1:0] addr
  );
    return addr[`SDRAM_ADDR_WIDTH-1 -: `SDRAM_BANK_WIDTH];
  endfunction

  function automatic logic [`SDRAM_ROW_WIDTH-1:0] port_row(
    input logic [`SDRAM_ADDR_WIDTH-1:0] addr
  );
    return addr[`SDRAM_COL_WIDTH +: `SDRAM_ROW_WIDTH];
  endfunction

  // Column is the low word address
  function automatic logic [`SDRAM_COL_WIDTH-1:0] port_col(
    input logic [`SDRAM_ADDR_WIDTH-1:0] addr
  );
    return addr[`SDRAM_COL_WIDTH-1:0];
  endfunction

endpackage

`default_nettype wire

/* sdram_init_sequencer.sv */
////////////////////////////////////////////////////////////
// SDRAM power-up sequencer
// Raises CKE, then precharge all, two refreshes, load mode
// Flags completion once tMRD has passed
////////////////////////////////////////////////////////////

`default_nettype none

`include "sdram_params.svh"

module sdram_init_sequencer
  import sdram_bus_pkg::*;
(
  input wire clk,
  input wire reset,
  output logic [3:0] init_cmd,
  output sdram_a_word_t init_a,
  output logic init_cke,
  output logic init_done
);

  // Milestones, each one period after the last
  localparam int CKE_AT = `SDRAM_INIT_CKE_CYCLES;
  localparam int PRECHARGE_AT = `SDRAM_INIT_PRECHARGE_CYCLES;
  localparam int REFRESH1_AT = PRECHARGE_AT + `SDRAM_T_RP_CYCLES;
  localparam int REFRESH2_AT = REFRESH1_AT + `SDRAM_T_RFC_CYCLES;
  localparam int LOAD_MODE_AT = REFRESH2_AT + `SDRAM_T_RFC_CYCLES;
  localparam int DONE_AT = LOAD_MODE_AT + `SDRAM_T_MRD_CYCLES;
  localparam int CNT_W = $clog2(DONE_AT + 1);

  logic [CNT_W-1:0] cycle_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_cnt <= '0;
      init_cmd <= `SDRAM_CMD_NOP;
      init_a <= '0;
      init_cke <= 1'b0;
      init_done <= 1'b0;
    end else begin
      // NOP between milestones
      init_cmd <= `SDRAM_CMD_NOP;
      init_a <= '0;

      // Counter parks on the last milestone
      if (cycle_cnt != CNT_W'(DONE_AT)) begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end

      if (cycle_cnt == CNT_W'(CKE_AT)) begin
        init_cke <= 1'b1;
      end

      if (cycle_cnt == CNT_W'(PRECHARGE_AT)) begin
        init_cmd <= `SDRAM_CMD_PRECHARGE;
        // A10 selects all banks
        init_a.row <= `SDRAM_ROW_WIDTH'(1 << 10);
      end else if (cycle_cnt == CNT_W'(REFRESH1_AT) ||
                   cycle_cnt == CNT_W'(REFRESH2_AT)) begin
        init_cmd <= `SDRAM_CMD_REFRESH;
      end else if (cycle_cnt == CNT_W'(LOAD_MODE_AT)) begin
        init_cmd <= `SDRAM_CMD_LOAD_MODE;
        init_a <= sdram_mode_word();
      end else if (cycle_cnt == CNT_W'(DONE_AT)) begin
        init_done <= 1'b1;
      end
    end
  end

  // Clock stays enabled for good once raised
  assert property (@(posedge clk) disable iff (reset) init_cke |=> init_cke)
    else $error("CKE dropped after power-up");

endmodule

`default_nettype wire

/* sdram_request_queue.sv */
////////////////////////////////////////////////////////////
// Port request queue
// Holds the latest write or read strobe until granted
////////////////////////////////////////////////////////////

`default_nettype none

`include "sdram_params.svh"

module sdram_request_queue (
  input wire clk,
  input wire reset,
  input wire [`SDRAM_ADDR_WIDTH-1:0] p0_addr,
  input wire [`SDRAM_DATA_WIDTH-1:0] p0_data,
  input wire [`SDRAM_DQM_WIDTH-1:0] p0_byte_en,
  input wire p0_wr_req,
  input wire p0_rd_req,
  input wire grant,
  output logic pend_wr,
  output logic pend_rd,
  output logic [`SDRAM_ADDR_WIDTH-1:0] pend_addr,
  output logic [`SDRAM_DATA_WIDTH-1:0] pend_data,
  output logic [`SDRAM_DQM_WIDTH-1:0] pend_byte_en
);

  // Pending flags, write wins over read
  always_ff @(posedge clk) begin
    if (reset) begin
      pend_wr <= 1'b0;
      pend_rd <= 1'b0;
    end else if (p0_wr_req) begin
      pend_wr <= 1'b1;
      pend_rd <= 1'b0;
    end else if (p0_rd_req) begin
      pend_wr <= 1'b0;
      pend_rd <= 1'b1;
    end else if (grant) begin
      pend_wr <= 1'b0;
      pend_rd <= 1'b0;
    end
  end

  // Operands of the newest strobe, an older one is overwritten
  always_ff @(posedge clk) begin
    if (p0_wr_req || p0_rd_req) begin
      pend_addr <= p0_addr;
      pend_data <= p0_data;
      pend_byte_en <= p0_byte_en;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(pend_wr && pend_rd))
    else $error("Write and read pending together");

endmodule

`default_nettype wire

/* sdram_access_scheduler.sv */
////////////////////////////////////////////////////////////
// SDRAM command scheduler
// Refresh versus access arbitration, ACTIVE then READ/WRITE
// with auto precharge, and the pin drivers after init
////////////////////////////////////////////////////////////

`default_nettype none

`include "sdram_params.svh"

module sdram_access_scheduler
  import sdram_bus_pkg::*;
  import sdram_port_pkg::*;
(
  input wire clk,
  input wire reset,
  input wire [3:0] init_cmd,
  input wire sdram_a_word_t init_a,
  input wire init_cke,
  input wire init_done,
  input wire pend_wr,
  input wire pend_rd,
  input wire [`SDRAM_ADDR_WIDTH-1:0] pend_addr,
  input wire [`SDRAM_DATA_WIDTH-1:0] pend_data,
  input wire [`SDRAM_DQM_WIDTH-1:0] pend_byte_en,
  output logic grant,
  output logic rd_issue,
  output logic wr_done,
  output logic p0_available,
  output logic init_complete,
  output logic [`SDRAM_DATA_WIDTH-1:0] sdram_dq_o,
  output logic sdram_dq_oe,
  output logic [`SDRAM_ROW_WIDTH-1:0] sdram_a,
  output logic [`SDRAM_BANK_WIDTH-1:0] sdram_ba,
  output logic [`SDRAM_DQM_WIDTH-1:0] sdram_dqm,
  output logic sdram_cke,
  output logic sdram_cs_n,
  output logic sdram_ras_n,
  output logic sdram_cas_n,
  output logic sdram_we_n
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_DELAY = 2'd1;
  localparam logic [1:0] ST_READ = 2'd2;
  localparam logic [1:0] ST_WRITE = 2'd3;

  localparam int DELAY_W = $clog2(`SDRAM_T_RFC_CYCLES + `SDRAM_WRITE_RECOVERY_CYCLES +
                                  `SDRAM_CAS_LATENCY + 2);
  localparam int REFRESH_W = $clog2(`SDRAM_REFRESH_INTERVAL + 1);
  // Read returns to idle together with the capture ready pulse
  localparam int READ_WAIT = `SDRAM_CAS_LATENCY + `SDRAM_FAST_INPUT;

  logic [1:0] state;
  logic [1:0] delay_target;
  logic [DELAY_W-1:0] delay_cnt;
  logic [REFRESH_W-1:0] refresh_cnt;
  logic refresh_due;
  logic wr_flag;
  logic [3:0] cmd_q;
  sdram_a_word_t a_q;
  sdram_a_word_t col_word;
  logic [`SDRAM_BANK_WIDTH-1:0] ba_q;
  logic [`SDRAM_COL_WIDTH-1:0] col_q;
  logic [`SDRAM_DATA_WIDTH-1:0] dq_q;
  logic [`SDRAM_DQM_WIDTH-1:0] be_q;
  logic [`SDRAM_DQM_WIDTH-1:0] dqm_q;

  assign refresh_due = refresh_cnt >= REFRESH_W'(`SDRAM_REFRESH_INTERVAL);
  // Refresh goes ahead of a waiting request
  assign grant = init_done && state == ST_IDLE && !refresh_due && (pend_wr || pend_rd);
  assign p0_available = init_done && state == ST_IDLE && !pend_wr && !pend_rd;
  assign init_complete = init_done;

  // Column word, auto precharge always set
  always_comb begin
    col_word.col_cmd.auto_precharge = 1'b1;
    col_word.col_cmd.unused = '0;
    col_word.col_cmd.col = col_q;
  end

  ////////////////////////////////////////////////////////////
  // Command FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      delay_target <= ST_IDLE;
      delay_cnt <= '0;
      refresh_cnt <= '0;
      wr_flag <= 1'b0;
      cmd_q <= `SDRAM_CMD_NOP;
      rd_issue <= 1'b0;
      wr_done <= 1'b0;
      sdram_dq_oe <= 1'b0;
    end else begin
      cmd_q <= `SDRAM_CMD_NOP;
      rd_issue <= 1'b0;
      wr_done <= 1'b0;
      sdram_dq_oe <= 1'b0;

      // Counter holds once a refresh is due
      if (init_done && !refresh_due) begin
        refresh_cnt <= refresh_cnt + 1'b1;
      end

      case (state)
        ST_IDLE: begin
          if (init_done && refresh_due) begin
            cmd_q <= `SDRAM_CMD_REFRESH;
            refresh_cnt <= '0;
            state <= ST_DELAY;
            delay_target <= ST_IDLE;
            delay_cnt <= DELAY_W'(`SDRAM_T_RFC_CYCLES - 2);
          end else if (grant) begin
            cmd_q <= `SDRAM_CMD_ACTIVE;
            state <= ST_DELAY;
            delay_target <= pend_wr ? ST_WRITE : ST_READ;
            wr_flag <= pend_wr;
            // Entering and leaving the delay take two of the tRCD cycles
            delay_cnt <= DELAY_W'(`SDRAM_T_RCD_CYCLES - 2);
          end
        end
        ST_DELAY: begin
          if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
          end else begin
            state <= delay_target;
            delay_target <= ST_IDLE;
            // End of write recovery finishes the write
            if (delay_target == ST_IDLE && wr_flag) begin
              wr_done <= 1'b1;
              wr_flag <= 1'b0;
            end
          end
        end
        ST_READ: begin
          cmd_q <= `SDRAM_CMD_READ;
          rd_issue <= 1'b1;
          state <= ST_DELAY;
          delay_cnt <= DELAY_W'(READ_WAIT);
        end
        default: begin
          cmd_q <= `SDRAM_CMD_WRITE;
          sdram_dq_oe <= 1'b1;
          state <= ST_DELAY;
          delay_cnt <= DELAY_W'(`SDRAM_WRITE_RECOVERY_CYCLES - 1);
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and data path

  always_ff @(posedge clk) begin
    // Latch the granted request, the queue may take a new one
    if (grant) begin
      ba_q <= port_bank(pend_addr);
      a_q.row <= port_row(pend_addr);
      col_q <= port_col(pend_addr);
      dq_q <= pend_data;
      be_q <= pend_byte_en;
    end
    if (state == ST_READ || state == ST_WRITE) begin
      a_q <= col_word;
    end
    // Reads fetch every byte, writes mask the disabled ones
    if (state == ST_READ) begin
      dqm_q <= '0;
    end else if (state == ST_WRITE) begin
      dqm_q <= ~be_q;
    end
  end

  // Init sequencer owns the command pins until it is done
  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = init_done ? cmd_q : init_cmd;
  assign sdram_a = init_done ? a_q : init_a;
  assign sdram_ba = init_done ? ba_q : '0;
  assign sdram_cke = init_cke;
  assign sdram_dq_o = dq_q;
  assign sdram_dqm = dqm_q;

  // No row is opened before the mode register is loaded
  assert property (@(posedge clk) disable iff (reset)
    ({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} == `SDRAM_CMD_ACTIVE) |-> init_done)
    else $error("ACTIVE issued during init");

endmodule

`default_nettype wire

/* sdram_read_capture.sv */
////////////////////////////////////////////////////////////
// SDRAM read return
// Samples DQ after CAS latency and the input register
////////////////////////////////////////////////////////////

`default_nettype none

`include "sdram_params.svh"

module sdram_read_capture (
  input wire clk,
  input wire reset,
  input wire rd_issue,
  input wire [`SDRAM_DATA_WIDTH-1:0] sdram_dq,
  output logic [`SDRAM_DATA_WIDTH-1:0] p0_q,
  output logic rd_ready
);

  localparam int DEPTH = `SDRAM_CAS_LATENCY + `SDRAM_FAST_INPUT;

  // One bit per read in flight
  logic [DEPTH-1:0] valid_sr;
  // Input register next to the pins
  logic [`SDRAM_DATA_WIDTH-1:0] dq_in;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_sr <= '0;
      rd_ready <= 1'b0;
    end else begin
      valid_sr <= (valid_sr << 1) | DEPTH'(rd_issue);
      rd_ready <= valid_sr[DEPTH-1];
    end
  end

  always_ff @(posedge clk) begin
    dq_in <= sdram_dq;
    if (valid_sr[DEPTH-1]) begin
      p0_q <= (`SDRAM_FAST_INPUT != 0) ? dq_in : sdram_dq;
    end
  end

  // Single word bursts, so each read returns one pulse
  assert property (@(posedge clk) disable iff (reset) rd_ready |=> !rd_ready)
    else $error("Read ready held for two cycles");

endmodule

`default_nettype wire

/* sdram_ctrl.sv */
////////////////////////////////////////////////////////////
// Single-port SDR SDRAM controller
// Init, request queue, scheduler and read return stages
////////////////////////////////////////////////////////////

`default_nettype none

`include "sdram_params.svh"

module sdram_ctrl
  import sdram_bus_pkg::*;
(
  input wire clk,
  input wire reset,
  input wire [`SDRAM_ADDR_WIDTH-1:0] p0_addr,
  input wire [`SDRAM_DATA_WIDTH-1:0] p0_data,
  input wire [`SDRAM_DQM_WIDTH-1:0] p0_byte_en,
  input wire p0_wr_req,
  input wire p0_rd_req,
  output logic [`SDRAM_DATA_WIDTH-1:0] p0_q,
  output logic p0_ready,
  output logic p0_available,
  output logic init_complete,
  input wire [`SDRAM_DATA_WIDTH-1:0] sdram_dq,
  output logic [`SDRAM_DATA_WIDTH-1:0] sdram_dq_o,
  output logic sdram_dq_oe,
  output logic [`SDRAM_ROW_WIDTH-1:0] sdram_a,
  output logic [`SDRAM_BANK_WIDTH-1:0] sdram_ba,
  output logic [`SDRAM_DQM_WIDTH-1:0] sdram_dqm,
  output logic sdram_cke,
  output logic sdram_cs_n,
  output logic sdram_ras_n,
  output logic sdram_cas_n,
  output logic sdram_we_n
);

  logic [3:0] init_cmd;
  sdram_a_word_t init_a;
  logic init_cke;
  logic init_done;
  logic pend_wr;
  logic pend_rd;
  logic [`SDRAM_ADDR_WIDTH-1:0] pend_addr;
  logic [`SDRAM_DATA_WIDTH-1:0] pend_data;
  logic [`SDRAM_DQM_WIDTH-1:0] pend_byte_en;
  logic grant;
  logic rd_issue;
  logic wr_done;
  logic rd_ready;

  sdram_init_sequencer i_init (
    .clk(clk),
    .reset(reset),
    .init_cmd(init_cmd),
    .init_a(init_a),
    .init_cke(init_cke),
    .init_done(init_done)
  );

  sdram_request_queue i_queue (
    .clk(clk),
    .reset(reset),
    .p0_addr(p0_addr),
    .p0_data(p0_data),
    .p0_byte_en(p0_byte_en),
    .p0_wr_req(p0_wr_req),
    .p0_rd_req(p0_rd_req),
    .grant(grant),
    .pend_wr(pend_wr),
    .pend_rd(pend_rd),
    .pend_addr(pend_addr),
    .pend_data(pend_data),
    .pend_byte_en(pend_byte_en)
  );

  sdram_access_scheduler i_sched (
    .clk(clk),
    .reset(reset),
    .init_cmd(init_cmd),
    .init_a(init_a),
    .init_cke(init_cke),
    .init_done(init_done),
    .pend_wr(pend_wr),
    .pend_rd(pend_rd),
    .pend_addr(pend_addr),
    .pend_data(pend_data),
    .pend_byte_en(pend_byte_en),
    .grant(grant),
    .rd_issue(rd_issue),
    .wr_done(wr_done),
    .p0_available(p0_available),
    .init_complete(init_complete),
    .sdram_dq_o(sdram_dq_o),
    .sdram_dq_oe(sdram_dq_oe),
    .sdram_a(sdram_a),
    .sdram_ba(sdram_ba),
    .sdram_dqm(sdram_dqm),
    .sdram_cke(sdram_cke),
    .sdram_cs_n(sdram_cs_n),
    .sdram_ras_n(sdram_ras_n),
    .sdram_cas_n(sdram_cas_n),
    .sdram_we_n(sdram_we_n)
  );

  sdram_read_capture i_capture (
    .clk(clk),
    .reset(reset),
    .rd_issue(rd_issue),
    .sdram_dq(sdram_dq),
    .p0_q(p0_q),
    .rd_ready(rd_ready)
  );

  // One access in flight, so the two pulses never overlap
  assign p0_ready = rd_ready | wr_done;

endmodule

`default_nettype wire

/* sdram_tb_model.sv */
////////////////////////////////////////////////////////////
// Behavioral SDR SDRAM model
// Decodes pin commands, stores 64 words, returns reads after
// CAS latency and checks the power-up command order
////////////////////////////////////////////////////////////

`default_nettype none

`include "sdram_params.svh"

module sdram_tb_model
  import sdram_bus_pkg::*;
(
  input wire clk,
  input wire reset,
  input wire [`SDRAM_DATA_WIDTH-1:0] sdram_dq_o,
  input wire sdram_dq_oe,
  input wire [`SDRAM_ROW_WIDTH-1:0] sdram_a,
  input wire [`SDRAM_BANK_WIDTH-1:0] sdram_ba,
  input wire [`SDRAM_DQM_WIDTH-1:0] sdram_dqm,
  input wire sdram_cke,
  input wire sdram_cs_n,
  input wire sdram_ras_n,
  input wire sdram_cas_n,
  input wire sdram_we_n,
  output logic [`SDRAM_DATA_WIDTH-1:0] sdram_dq,
  output logic [2:0] init_step,
  output logic protocol_error,
  output sdram_a_word_t mode_word,
  output int refresh_count
);

  localparam int CL = `SDRAM_CAS_LATENCY;

  logic [3:0] cmd;
  sdram_a_word_t a_word;
  // Bank plus low column bits
  logic [5:0] idx;
  logic [(1 << `SDRAM_BANK_WIDTH)-1:0] open_bank;
  logic [CL-1:0] rd_valid;
  logic [`SDRAM_DATA_WIDTH-1:0] rd_data [CL];
  logic [`SDRAM_DATA_WIDTH-1:0] mem [64];

  assign cmd = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};
  assign a_word = sdram_a;
  assign idx = {sdram_ba, a_word.col_cmd.col[3:0]};
  // Data valid from CL-1 edges after READ until edge CL
  assign sdram_dq = rd_valid[CL-1] ? rd_data[CL-1] : 'x;

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'hc0de_0000 | 32'(i * 32'h0101);
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      init_step <= 3'd0;
      protocol_error <= 1'b0;
      refresh_count <= 0;
      open_bank <= '0;
      rd_valid <= '0;
    end else begin
      // Read return pipeline
      rd_valid <= (rd_valid << 1) | CL'(cmd == `SDRAM_CMD_READ);
      for (int i = CL - 1; i > 0; i--) begin
        rd_data[i] <= rd_data[i-1];
      end
      rd_data[0] <= mem[idx];

      if (init_step == 3'd0 && sdram_cke) begin
        init_step <= 3'd1;
      end

      // Steps: 1 CKE, 2 precharge, 3 and 4 refresh, 5 mode loaded
      case (cmd)
        `SDRAM_CMD_NOP: begin
        end
        `SDRAM_CMD_PRECHARGE: begin
          if (init_step != 3'd1 || !a_word.row[10]) protocol_error <= 1'b1;
          else init_step <= 3'd2;
        end
        `SDRAM_CMD_REFRESH: begin
          if (init_step == 3'd2 || init_step == 3'd3) init_step <= init_step + 3'd1;
          else if (init_step == 3'd5) refresh_count <= refresh_count + 1;
          else protocol_error <= 1'b1;
        end
        `SDRAM_CMD_LOAD_MODE: begin
          if (init_step != 3'd4) begin
            protocol_error <= 1'b1;
          end else begin
            init_step <= 3'd5;
            mode_word <= a_word;
          end
        end
        `SDRAM_CMD_ACTIVE: begin
          if (init_step != 3'd5) protocol_error <= 1'b1;
          open_bank[sdram_ba] <= 1'b1;
        end
        `SDRAM_CMD_READ, `SDRAM_CMD_WRITE: begin
          // Needs an open row, and auto precharge closes it
          if (init_step != 3'd5 || !open_bank[sdram_ba] || !a_word.col_cmd.auto_precharge)
            protocol_error <= 1'b1;
          open_bank[sdram_ba] <= 1'b0;
          if (cmd == `SDRAM_CMD_WRITE) begin
            if (!sdram_dq_oe) protocol_error <= 1'b1;
            // DQM high masks a byte
            for (int b = 0; b < `SDRAM_DQM_WIDTH; b++) begin
              if (!sdram_dqm[b]) mem[idx][8*b +: 8] <= sdram_dq_o[8*b +: 8];
            end
          end
        end
        default: protocol_error <= 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

/* sdram_tb.sv */
////////////////////////////////////////////////////////////
// SDRAM controller testbench
// Init order, write/read pairs with byte merges, requests
// queued while busy, ready pulses and refresh rate
////////////////////////////////////////////////////////////

`default_nettype none

`include "sdram_params.svh"

module sdram_tb
  import sdram_bus_pkg::*;
();

  localparam int NUM_ADDRS = 8;
  localparam int NUM_ROWS = NUM_ADDRS * 4;
  localparam int INIT_CYCLES = `SDRAM_INIT_PRECHARGE_CYCLES + `SDRAM_T_RP_CYCLES +
                               2 * `SDRAM_T_RFC_CYCLES + `SDRAM_T_MRD_CYCLES;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + INIT_CYCLES + `SDRAM_REFRESH_INTERVAL + 100;
  localparam logic [3:0] NOP_CMD = `SDRAM_CMD_NOP;

  logic clk;
  logic reset;
  logic [`SDRAM_ADDR_WIDTH-1:0] p0_addr;
  logic [`SDRAM_DATA_WIDTH-1:0] p0_data;
  logic [`SDRAM_DQM_WIDTH-1:0] p0_byte_en;
  logic p0_wr_req;
  logic p0_rd_req;
  logic [`SDRAM_DATA_WIDTH-1:0] p0_q;
  logic p0_ready;
  logic p0_available;
  logic init_complete;
  logic [`SDRAM_DATA_WIDTH-1:0] sdram_dq;
  logic [`SDRAM_DATA_WIDTH-1:0] sdram_dq_o;
  logic sdram_dq_oe;
  logic [`SDRAM_ROW_WIDTH-1:0] sdram_a;
  logic [`SDRAM_BANK_WIDTH-1:0] sdram_ba;
  logic [`SDRAM_DQM_WIDTH-1:0] sdram_dqm;
  logic sdram_cke;
  logic sdram_cs_n;
  logic sdram_ras_n;
  logic sdram_cas_n;
  logic sdram_we_n;
  logic [2:0] init_step;
  logic protocol_error;
  sdram_a_word_t mode_word;
  int refresh_count;

  // Stimulus table, one row per request
  logic tbl_write [NUM_ROWS];
  logic tbl_early [NUM_ROWS];
  logic [`SDRAM_ADDR_WIDTH-1:0] tbl_addr [NUM_ROWS];
  logic [`SDRAM_DATA_WIDTH-1:0] tbl_data [NUM_ROWS];
  logic [`SDRAM_DQM_WIDTH-1:0] tbl_be [NUM_ROWS];
  logic [`SDRAM_DATA_WIDTH-1:0] tbl_exp [NUM_ROWS];

  // Responses still owed by the DUT
  logic exp_is_read [$];
  logic [`SDRAM_DATA_WIDTH-1:0] exp_data [$];
  logic [31:0] lfsr;
  logic ready_prev;
  int cycles;
  int outstanding;
  int strobe_cnt;
  int active_cnt;

  sdram_ctrl i_dut (.*);

  sdram_tb_model i_model (.*);

  always #5 clk = ~clk;

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    abort_run();
  endtask

  task automatic check_word(input string name, input logic [`SDRAM_DATA_WIDTH-1:0] actual,
                            input logic [`SDRAM_DATA_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_a_word(input string name, input sdram_a_word_t actual,
                              input sdram_a_word_t expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  // 32-bit Fibonacci LFSR, taps 32, 22, 2, 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] be);
    logic [31:0] w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) w[8*b +: 8] = new_word[8*b +: 8];
    end
    return w;
  endfunction

  // Per address: full write, read, partial write, read
  task automatic build_table();
    logic [`SDRAM_DATA_WIDTH-1:0] shadow [NUM_ADDRS];
    logic [`SDRAM_ADDR_WIDTH-1:0] addr;
    logic [3:0] be;
    int r;
    lfsr = 32'h54ad;
    for (int k = 0; k < NUM_ADDRS; k++) begin
      shadow[k] = '0;
      // Low column bits and bank keep the model slots apart
      addr = {2'(k), 11'(random_bits(11)), 4'(random_bits(4)), 1'b0, 3'(k)};
      for (int j = 0; j < 4; j++) begin
        r = 4 * k + j;
        tbl_addr[r] = addr;
        tbl_write[r] = (j % 2 == 0);
        // Reads queued behind a busy write
        tbl_early[r] = (j == 1 && k % 2 == 1) || (j == 3 && k % 2 == 0);
        be = 4'hf;
        tbl_data[r] = '0;
        if (tbl_write[r]) begin
          tbl_data[r] = random_bits(32);
          if (j == 2) begin
            be = 4'(random_bits(4));
            if (be == 4'hf || be == 4'h0) be = 4'b0110;
          end
          shadow[k] = merge_bytes(shadow[k], tbl_data[r], be);
        end
        tbl_be[r] = be;
        tbl_exp[r] = shadow[k];
      end
    end
  endtask

  // One cycle, outputs sampled at the falling edge
  task automatic tick();
    logic is_rd;
    logic [`SDRAM_DATA_WIDTH-1:0] data;
    @(negedge clk);
    cycles++;
    if (cycles > TIMEOUT_CYCLES) report_error("timeout, the run exceeded its cycle limit");
    if (protocol_error) report_error("SDRAM model saw a command out of order or before CKE");
    if (ready_prev) check_bit("p0_ready", p0_ready, 1'b0);
    ready_prev = p0_ready;
    if (p0_ready) begin
      if (outstanding == 0) report_error("p0_ready pulsed with no request outstanding");
      outstanding--;
      is_rd = exp_is_read.pop_front();
      data = exp_data.pop_front();
      if (is_rd) check_word("p0_q", p0_q, data);
    end
    if (outstanding > 0) check_bit("p0_available", p0_available, 1'b0);
    if ({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} == `SDRAM_CMD_ACTIVE) active_cnt++;
  endtask

  initial begin
    sdram_a_word_t expected_mode;
    int init_start;
    int min_refresh;
    clk = 1'b0;
    reset = 1'b1;
    p0_addr = '0;
    p0_data = '0;
    p0_byte_en = '0;
    p0_wr_req = 1'b0;
    p0_rd_req = 1'b0;
    ready_prev = 1'b0;
    cycles = 0;
    outstanding = 0;
    strobe_cnt = 0;
    active_cnt = 0;
    build_table();

    repeat (3) tick();
    check_bit("sdram_cke", sdram_cke, 1'b0);
    check_bit("init_complete", init_complete, 1'b0);
    check_bit("p0_ready", p0_ready, 1'b0);
    check_bit("p0_available", p0_available, 1'b0);
    check_bit("sdram_dq_oe", sdram_dq_oe, 1'b0);
    check_bit("sdram_cs_n", sdram_cs_n, NOP_CMD[3]);
    check_bit("sdram_ras_n", sdram_ras_n, NOP_CMD[2]);
    check_bit("sdram_cas_n", sdram_cas_n, NOP_CMD[1]);
    check_bit("sdram_we_n", sdram_we_n, NOP_CMD[0]);
    reset = 1'b0;
    init_start = cycles;

    ////////////////////////////////////////////////////////////
    // Power-up

    while (!init_complete) begin
      if (cycles - init_start > INIT_CYCLES + 2)
        report_error("init_complete did not rise within the init time");
      tick();
    end
    if (init_step != 3'd5) report_error("SDRAM model did not see the whole init sequence");
    // JEDEC layout: BL 1, sequential, single write, CAS latency
    expected_mode.row = {1'b0, 1'b1, 2'b00, 3'(`SDRAM_CAS_LATENCY), 1'b0, 3'b000};
    check_a_word("mode_word", mode_word, expected_mode);
    init_start = cycles;

    ////////////////////////////////////////////////////////////
    // Table

    for (int i = 0; i < NUM_ROWS; i++) begin
      if (tbl_early[i]) begin
        // Strobe once the previous access has opened its row
        while (active_cnt != strobe_cnt) tick();
        check_bit("p0_available", p0_available, 1'b0);
      end else begin
        while (outstanding != 0 || !p0_available) tick();
      end
      p0_addr = tbl_addr[i];
      p0_data = tbl_data[i];
      p0_byte_en = tbl_be[i];
      p0_wr_req = tbl_write[i];
      p0_rd_req = !tbl_write[i];
      exp_is_read.push_back(!tbl_write[i]);
      exp_data.push_back(tbl_exp[i]);
      outstanding++;
      strobe_cnt++;
      tick();
      p0_wr_req = 1'b0;
      p0_rd_req = 1'b0;
    end
    while (outstanding != 0) tick();

    // Idle long enough for at least one more refresh
    repeat (`SDRAM_REFRESH_INTERVAL + 20) tick();
    min_refresh = (cycles - init_start) / `SDRAM_REFRESH_INTERVAL - 1;
    if (refresh_count < min_refresh) begin
      report_error("too few auto refreshes during the run");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sdram_ctrl.f */
+incdir+.
sdram_bus_pkg.sv
sdram_port_pkg.sv
sdram_init_sequencer.sv
sdram_request_queue.sv
sdram_access_scheduler.sv
sdram_read_capture.sv
sdram_ctrl.sv
sdram_tb_model.sv
sdram_tb.sv

/* Bender.yml */
package:
  name: sdram_ctrl

export_include_dirs:
  - .

sources:
  - files:
      - sdram_bus_pkg.sv
      - sdram_port_pkg.sv
      - sdram_init_sequencer.sv
      - sdram_request_queue.sv
      - sdram_access_scheduler.sv
      - sdram_read_capture.sv
      - sdram_ctrl.sv
  - target: test
    files:
      - sdram_tb_model.sv
      - sdram_tb.sv
